// File: hw/fir_pkg.sv
package fir_pkg;

   // ============================================================
   // Filter geometry
   // ============================================================

   // Tap count, also half the operand count of the MAC tree
   localparam int NUM_TAPS = 4;

   // ============================================================
   // APB request and response
   // ============================================================

   // Master side of one APB transfer
   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [7:0]  paddr;
      logic [31:0] pwdata;
   } apb_req_t;

   // Slave side, pready tied high by the register block
   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apb_rsp_t;

   // ============================================================
   // Register map
   // ============================================================

   localparam logic [7:0] ADDR_CTRL   = 8'h00;
   // Coefficient bank at 0x04, 0x08, 0x0C and 0x10
   localparam logic [7:0] ADDR_COEFF0 = 8'h04;
   // Read only result counter
   localparam logic [7:0] ADDR_COUNT  = 8'h14;

   // Control word bit positions
   localparam int CTRL_ENABLE = 0;
   localparam int CTRL_CLEAR  = 1;

endpackage

// File: hw/mac_tree.sv
`timescale 1ns/100ps

module mac_tree #(
   parameter int WIDTH = 16
) (
   input  logic             clk,
   input  logic             rst,
   input  logic [WIDTH-1:0] operands[8],
   input  logic             operands_valid,
   output logic [WIDTH-1:0] result,
   output logic             result_valid
);

   // Operand count and cycle latency of the tree
   localparam int NUM_OPS = 8;
   localparam int LATENCY = 4;

   logic [WIDTH-1:0]   in_r[NUM_OPS];
   logic [WIDTH-1:0]   mult_r[NUM_OPS/2];
   logic [WIDTH-1:0]   add_r[NUM_OPS/4];
   logic [WIDTH-1:0]   sum_r;
   logic [LATENCY-1:0] valid_delay_r;

   // ============================================================
   // Datapath
   // ============================================================

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < NUM_OPS; i++) begin
            in_r[i] <= '0;
         end
         for (int i = 0; i < NUM_OPS / 2; i++) begin
            mult_r[i] <= '0;
         end
         for (int i = 0; i < NUM_OPS / 4; i++) begin
            add_r[i] <= '0;
         end
         sum_r <= '0;
      end else begin
         // Stage 1 input capture
         for (int i = 0; i < NUM_OPS; i++) begin
            in_r[i] <= operands[i];
         end
         // Stage 2 products of adjacent pairs, high half dropped
         for (int i = 0; i < NUM_OPS / 2; i++) begin
            mult_r[i] <= in_r[2*i] * in_r[2*i+1];
         end
         // Stage 3 first adder level
         for (int i = 0; i < NUM_OPS / 4; i++) begin
            add_r[i] <= mult_r[2*i] + mult_r[2*i+1];
         end
         // Stage 4 final sum
         sum_r <= add_r[0] + add_r[1];
      end
   end

   // ============================================================
   // Valid tracking
   // ============================================================

   // One bit per stage, oldest at the top
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_delay_r <= '0;
      end else begin
         valid_delay_r <= {valid_delay_r[LATENCY-2:0], operands_valid};
      end
   end

   assign result       = sum_r;
   assign result_valid = valid_delay_r[LATENCY-1];

endmodule

// File: hw/fir_tap_line.sv
`timescale 1ns/100ps

module fir_tap_line #(
   parameter int WIDTH = 16
) (
   input  logic             clk,
   input  logic             rst,
   input  logic [WIDTH-1:0] sample,
   input  logic             sample_valid,
   input  logic             enable,
   input  logic             clear,
   input  logic [WIDTH-1:0] coeff[fir_pkg::NUM_TAPS],
   output logic [WIDTH-1:0] operands[2*fir_pkg::NUM_TAPS],
   output logic             operands_valid
);

   localparam int TAPS = fir_pkg::NUM_TAPS;

   logic             accept;
   // Older samples, the newest one sits in the operand register
   logic [WIDTH-1:0] hist_r[TAPS-1];
   // Window after the incoming sample shifts in, index 0 newest
   logic [WIDTH-1:0] line_next[TAPS];
   logic [WIDTH-1:0] operands_r[2*TAPS];
   logic             operands_valid_r;

   // Clear drops a sample offered in the same cycle
   assign accept = sample_valid & enable & ~clear;

   always_comb begin
      line_next[0] = sample;
      for (int k = 1; k < TAPS; k++) begin
         line_next[k] = hist_r[k-1];
      end
   end

   // ============================================================
   // Delay line
   // ============================================================

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int k = 0; k < TAPS - 1; k++) begin
            hist_r[k] <= '0;
         end
      end else if (clear) begin
         for (int k = 0; k < TAPS - 1; k++) begin
            hist_r[k] <= '0;
         end
      end else if (accept) begin
         for (int k = 0; k < TAPS - 1; k++) begin
            hist_r[k] <= line_next[k];
         end
      end
   end

   // Coefficient and sample interleaved, captured at the sample edge
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         operands_valid_r <= 1'b0;
         for (int k = 0; k < 2 * TAPS; k++) begin
            operands_r[k] <= '0;
         end
      end else begin
         operands_valid_r <= accept;
         if (accept) begin
            for (int k = 0; k < TAPS; k++) begin
               operands_r[2*k]   <= coeff[k];
               operands_r[2*k+1] <= line_next[k];
            end
         end
      end
   end

   assign operands       = operands_r;
   assign operands_valid = operands_valid_r;

endmodule

// File: hw/fir_apb_regs.sv
`timescale 1ns/100ps

module fir_apb_regs #(
   parameter int WIDTH = 16
) (
   input  logic              clk,
   input  logic              rst,
   input  fir_pkg::apb_req_t apb_req,
   output fir_pkg::apb_rsp_t apb_rsp,
   output logic [WIDTH-1:0]  coeff[fir_pkg::NUM_TAPS],
   output logic              enable,
   output logic              clear,
   input  logic              result_valid
);

   // Index width into the coefficient bank
   localparam int IDX_W = $clog2(fir_pkg::NUM_TAPS);

   logic             access;
   logic             ctrl_hit;
   logic             count_hit;
   logic             coeff_hit;
   logic [IDX_W-1:0] coeff_idx;
   logic             err;
   logic             wr_ok;
   logic [31:0]      rd_data;
   logic [WIDTH-1:0] coeff_r[fir_pkg::NUM_TAPS];
   logic             enable_r;
   logic             clear_r;
   logic [15:0]      count_r;

   // ============================================================
   // Address decode
   // ============================================================

   // Access phase of a transfer
   assign access    = apb_req.psel & apb_req.penable;
   assign ctrl_hit  = apb_req.paddr == fir_pkg::ADDR_CTRL;
   assign count_hit = apb_req.paddr == fir_pkg::ADDR_COUNT;

   // Coefficient slots are one word apart
   always_comb begin
      coeff_hit = 1'b0;
      coeff_idx = '0;
      for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
         if (apb_req.paddr == fir_pkg::ADDR_COEFF0 + 8'(4 * i)) begin
            coeff_hit = 1'b1;
            coeff_idx = IDX_W'(i);
         end
      end
   end

   // Unmapped address or write to the counter
   assign err   = access & (~(ctrl_hit | count_hit | coeff_hit) | (apb_req.pwrite & count_hit));
   assign wr_ok = access & apb_req.pwrite & ~err;

   // Read mux, zero-extended to the bus width
   always_comb begin
      rd_data = '0;
      if (ctrl_hit) begin
         rd_data[fir_pkg::CTRL_ENABLE] = enable_r;
      end else if (count_hit) begin
         rd_data[15:0] = count_r;
      end else if (coeff_hit) begin
         rd_data[WIDTH-1:0] = coeff_r[coeff_idx];
      end
   end

   // No wait states
   always_comb begin
      apb_rsp.prdata  = rd_data;
      apb_rsp.pready  = 1'b1;
      apb_rsp.pslverr = err;
   end

   // ============================================================
   // Register storage
   // ============================================================

   // Enable level and one-cycle clear pulse
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         enable_r <= 1'b0;
         clear_r  <= 1'b0;
      end else begin
         clear_r <= 1'b0;
         if (wr_ok && ctrl_hit) begin
            enable_r <= apb_req.pwdata[fir_pkg::CTRL_ENABLE];
            clear_r  <= apb_req.pwdata[fir_pkg::CTRL_CLEAR];
         end
      end
   end

   // Coefficient bank, upper bits of the write dropped
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
            coeff_r[i] <= '0;
         end
      end else if (wr_ok && coeff_hit) begin
         coeff_r[coeff_idx] <= apb_req.pwdata[WIDTH-1:0];
      end
   end

   // Completed results, wraps at 16 bits
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         count_r <= '0;
      end else if (result_valid) begin
         count_r <= count_r + 16'd1;
      end
   end

   assign coeff  = coeff_r;
   assign enable = enable_r;
   assign clear  = clear_r;

endmodule

// File: hw/fir_top.sv
`timescale 1ns/100ps

module fir_top #(
   parameter int WIDTH = 16
) (
   input  logic              clk,
   input  logic              rst,
   input  fir_pkg::apb_req_t apb_req,
   output fir_pkg::apb_rsp_t apb_rsp,
   input  logic [WIDTH-1:0]  sample,
   input  logic              sample_valid,
   output logic [WIDTH-1:0]  result,
   output logic              result_valid
);

   // Register block outputs
   logic [WIDTH-1:0] coeff[fir_pkg::NUM_TAPS];
   logic             enable;
   logic             clear;

   // Tap line to MAC tree
   logic [WIDTH-1:0] operands[2*fir_pkg::NUM_TAPS];
   logic             operands_valid;

   // ============================================================
   // Control and status registers
   // ============================================================

   // Result strobe also feeds the readback counter
   fir_apb_regs #(
      .WIDTH(WIDTH)
   ) u_regs (
      .clk         (clk),
      .rst         (rst),
      .apb_req     (apb_req),
      .apb_rsp     (apb_rsp),
      .coeff       (coeff),
      .enable      (enable),
      .clear       (clear),
      .result_valid(result_valid)
   );

   // ============================================================
   // Filter datapath
   // ============================================================

   // Sample to operands in 1 cycle
   fir_tap_line #(
      .WIDTH(WIDTH)
   ) u_taps (
      .clk           (clk),
      .rst           (rst),
      .sample        (sample),
      .sample_valid  (sample_valid),
      .enable        (enable),
      .clear         (clear),
      .coeff         (coeff),
      .operands      (operands),
      .operands_valid(operands_valid)
   );

   // Operands to result in 4 cycles
   mac_tree #(
      .WIDTH(WIDTH)
   ) u_mac (
      .clk           (clk),
      .rst           (rst),
      .operands      (operands),
      .operands_valid(operands_valid),
      .result        (result),
      .result_valid  (result_valid)
   );

endmodule

// File: verif/fir_props.sv
`timescale 1ns/100ps

module fir_props (
   input logic clk,
   input logic rst,
   input logic in_valid,
   input logic out_valid,
   input logic pslverr,
   input logic penable
);

   // Read back by the testbench at the end of the run
   int fail_cnt = 0;

   // Pipeline holds zeros for its full depth after reset
   a_quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !out_valid [*4])
   else begin
      fail_cnt++;
      $error("result_valid high within 4 cycles of reset");
   end

   // ============================================================
   // Valid delay line, 4 cycles each way
   // ============================================================

   a_valid_forward: assert property (@(posedge clk) disable iff (rst)
                                     in_valid |-> ##4 out_valid)
   else begin
      fail_cnt++;
      $error("Valid input not followed by result_valid 4 cycles later");
   end

   a_valid_backward: assert property (@(posedge clk) disable iff (rst)
                                      out_valid |-> $past(in_valid, 4))
   else begin
      fail_cnt++;
      $error("result_valid without a valid input 4 cycles earlier");
   end

   // Slave error only in the access phase
   a_err_in_access: assert property (@(posedge clk) disable iff (rst) pslverr |-> penable)
   else begin
      fail_cnt++;
      $error("pslverr outside an access cycle");
   end

endmodule

// MAC tree has no bus, so its error inputs are tied off
bind mac_tree fir_props u_props (
   .clk      (clk),
   .rst      (rst),
   .in_valid (operands_valid),
   .out_valid(result_valid),
   .pslverr  (1'b0),
   .penable  (1'b0)
);

bind fir_top fir_props u_props (
   .clk      (clk),
   .rst      (rst),
   .in_valid (operands_valid),
   .out_valid(result_valid),
   .pslverr  (apb_rsp.pslverr),
   .penable  (apb_req.penable)
);

// File: verif/fir_tb.sv
`timescale 1ns/100ps

module fir_tb;

   localparam int WIDTH = 16;
   localparam int TAPS  = fir_pkg::NUM_TAPS;

   logic              clk;
   logic              rst;
   fir_pkg::apb_req_t apb_req;
   fir_pkg::apb_rsp_t apb_rsp;
   logic [WIDTH-1:0]  sample;
   logic              sample_valid;
   logic [WIDTH-1:0]  result;
   logic              result_valid;

   // Reference model state, tap 0 newest
   logic [WIDTH-1:0] coeff_m[TAPS];
   logic [WIDTH-1:0] hist_m[TAPS];
   logic             enable_m;
   // Expected results and the falling edge each one is due on
   logic [WIDTH-1:0] exp_q[$];
   int               due_q[$];
   int               edge_cnt;
   int               errors;
   int               results_seen;
   int               assert_fails;

   fir_top #(
      .WIDTH(WIDTH)
   ) u_dut (
      .clk         (clk),
      .rst         (rst),
      .apb_req     (apb_req),
      .apb_rsp     (apb_rsp),
      .sample      (sample),
      .sample_valid(sample_valid),
      .result      (result),
      .result_valid(result_valid)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Hard stop for the whole run
   initial begin
      repeat (20000) @(posedge clk);
      $display("Run did not finish within 20000 cycles");
      $display("Something failed");
      $finish;
   end

   // ============================================================
   // Result monitor
   // ============================================================

   // Sampled on the falling edge, away from the driving edge
   always @(negedge clk) begin
      edge_cnt++;
      if (!rst && result_valid) begin
         results_seen++;
         if (exp_q.size() == 0) begin
            errors++;
            $display("Result %h at %0t arrived with no sample pending", result, $time);
         end else begin
            if (result !== exp_q[0]) begin
               errors++;
               $display("FAIL %0t result got %h expected %h", $time, result, exp_q[0]);
            end
            if (edge_cnt != due_q[0]) begin
               errors++;
               $display("FAIL %0t result_valid cycle got %0d expected %0d",
                        $time, edge_cnt, due_q[0]);
            end
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
         end
      end
   end

   // ============================================================
   // APB tasks
   // ============================================================

   function automatic logic [7:0] coeff_addr(input int k);
      return fir_pkg::ADDR_COEFF0 + 8'(4 * k);
   endfunction

   // Setup cycle, access cycle, then idle
   task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                           input logic [31:0] exp_rd, input logic exp_err);
      int waits;
      @(posedge clk);
      apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
      @(posedge clk);
      apb_req.penable <= 1'b1;
      @(negedge clk);
      waits = 0;
      while (!apb_rsp.pready && waits < 16) begin
         @(negedge clk);
         waits++;
      end
      if (!apb_rsp.pready) begin
         errors++;
         $display("APB transfer to address %h never completed", addr);
      end
      if (apb_rsp.pslverr !== exp_err) begin
         errors++;
         $display("FAIL %0t pslverr got %b expected %b", $time, apb_rsp.pslverr, exp_err);
      end
      if (!wr && apb_rsp.prdata !== exp_rd) begin
         errors++;
         $display("FAIL %0t prdata got %h expected %h", $time, apb_rsp.prdata, exp_rd);
      end
      // Write lands on this edge
      @(posedge clk);
      apb_req <= '0;
   endtask

   task automatic reg_write(input logic [7:0] addr, input logic [31:0] data, input logic err);
      apb_xfer(1'b1, addr, data, 32'h0, err);
   endtask

   task automatic reg_read(input logic [7:0] addr, input logic [31:0] exp, input logic err);
      apb_xfer(1'b0, addr, 32'h0, exp, err);
   endtask

   // Random bank, read back truncated to WIDTH and zero-extended
   task automatic load_coeffs();
      logic [31:0] w;
      for (int k = 0; k < TAPS; k++) begin
         w = $urandom;
         reg_write(coeff_addr(k), w, 1'b0);
         coeff_m[k] = w[WIDTH-1:0];
         reg_read(coeff_addr(k), 32'(w[WIDTH-1:0]), 1'b0);
      end
   endtask

   task automatic set_ctrl(input logic en, input logic clr);
      logic [31:0] w;
      w = '0;
      w[fir_pkg::CTRL_ENABLE] = en;
      w[fir_pkg::CTRL_CLEAR]  = clr;
      reg_write(fir_pkg::ADDR_CTRL, w, 1'b0);
      enable_m = en;
      if (clr) begin
         for (int k = 0; k < TAPS; k++) begin
            hist_m[k] = '0;
         end
      end
   endtask

   // ============================================================
   // Sample stream and model
   // ============================================================

   // Presented now, accepted next edge, result on the 5th edge from there
   task automatic offer_sample(input logic [WIDTH-1:0] s);
      logic [WIDTH-1:0] acc;
      sample       <= s;
      sample_valid <= 1'b1;
      if (enable_m) begin
         for (int k = TAPS - 1; k > 0; k--) begin
            hist_m[k] = hist_m[k-1];
         end
         hist_m[0] = s;
         acc = '0;
         // Sum of products wraps at WIDTH bits
         for (int k = 0; k < TAPS; k++) begin
            acc = acc + coeff_m[k] * hist_m[k];
         end
         exp_q.push_back(acc);
         due_q.push_back(edge_cnt + 6);
      end
   endtask

   // Random data with random idle gaps
   task automatic stream_samples(input int n);
      int sent;
      sent = 0;
      while (sent < n) begin
         @(posedge clk);
         if ($urandom_range(3) == 0) begin
            sample_valid <= 1'b0;
         end else begin
            offer_sample(WIDTH'($urandom));
            sent++;
         end
      end
      @(posedge clk);
      sample_valid <= 1'b0;
   endtask

   task automatic wait_drain();
      int waits;
      waits = 0;
      while (exp_q.size() != 0 && waits < 64) begin
         @(posedge clk);
         waits++;
      end
      if (exp_q.size() != 0) begin
         errors++;
         $display("%0d results still missing after 64 cycles", exp_q.size());
      end
   endtask

   // ============================================================
   // Test sequence
   // ============================================================

   initial begin
      void'($urandom(32'hb1fb_65b7));
      rst          = 1'b1;
      apb_req      = '0;
      sample       = '0;
      sample_valid = 1'b0;
      enable_m     = 1'b0;
      for (int k = 0; k < TAPS; k++) begin
         coeff_m[k] = '0;
         hist_m[k]  = '0;
      end
      repeat (3) @(posedge clk);
      rst <= 1'b0;

      // Reset values, monitor flags any stray result
      reg_read(fir_pkg::ADDR_CTRL, 32'h0, 1'b0);
      for (int k = 0; k < TAPS; k++) begin
         reg_read(coeff_addr(k), 32'h0, 1'b0);
      end
      reg_read(fir_pkg::ADDR_COUNT, 32'h0, 1'b0);

      // Coefficient readback and slave errors
      load_coeffs();
      reg_read(8'h18, 32'h0, 1'b1);
      reg_write(8'h02, 32'hffff_ffff, 1'b1);
      reg_write(fir_pkg::ADDR_COUNT, 32'h55, 1'b1);
      reg_read(fir_pkg::ADDR_COUNT, 32'h0, 1'b0);

      // Enabled stream
      set_ctrl(1'b1, 1'b0);
      reg_read(fir_pkg::ADDR_CTRL, 32'h1, 1'b0);
      stream_samples(40);
      wait_drain();

      // Disabled samples neither produce results nor shift the line
      set_ctrl(1'b0, 1'b0);
      stream_samples(12);
      repeat (10) @(posedge clk);
      set_ctrl(1'b1, 1'b0);
      stream_samples(8);
      wait_drain();

      // Clear while earlier results are still in the pipeline
      stream_samples(6);
      set_ctrl(1'b1, 1'b1);
      reg_read(fir_pkg::ADDR_CTRL, 32'h1, 1'b0);
      stream_samples(10);
      wait_drain();

      // New coefficients between bursts
      stream_samples(10);
      load_coeffs();
      stream_samples(10);
      wait_drain();
      reg_read(fir_pkg::ADDR_COUNT, 32'(16'(results_seen)), 1'b0);

      assert_fails = u_dut.u_props.fail_cnt + u_dut.u_mac.u_props.fail_cnt;
      $display("Errors: %0d, assertion failures: %0d, results checked: %0d",
               errors, assert_fails, results_seen);
      if (errors == 0 && assert_fails == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// File: fir_top.f
hw/fir_pkg.sv
hw/mac_tree.sv
hw/fir_tap_line.sv
hw/fir_apb_regs.sv
hw/fir_top.sv
verif/fir_props.sv
verif/fir_tb.sv

// File: Bender.yml
package:
  name: fir_top

sources:
  - files:
      - hw/fir_pkg.sv
      - hw/mac_tree.sv
      - hw/fir_tap_line.sv
      - hw/fir_apb_regs.sv
      - hw/fir_top.sv
  - target: test
    files:
      - verif/fir_props.sv
      - verif/fir_tb.sv
